/* files.f */
+incdir+src
+incdir+tests
src/soc_bus_pkg.sv
src/bus_ctrl.sv
src/ram_bank.sv
src/plic_regs.sv
src/soc_bus_top.sv
tests/tb_soc_bus.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_soc_bus
FILELIST := files.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard src/*.sv src/*.svh tests/*.sv tests/*.svh)
PASS_MSG := Simulation completed successfully

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// byte image of the first 16 ram words
localparam int WINDOW_BYTES = 64;

logic [7:0]         ram_image [WINDOW_BYTES];

// interrupt controller state, context 0 is M and context 1 is S
logic [31:0]        pending_model;
logic [31:0]        enable_model [2];
logic [`PRIO_W-1:0] prio_model [`PLIC_SOURCES];
logic [`PRIO_W-1:0] thresh_model [2];

// bytes touched by one access of this type
function automatic int access_size(input ls_type_e t);
    case (t)
        LS_BYTE, LS_BYTE_U: return 1;
        LS_HALF, LS_HALF_U: return 2;
        LS_DOUBLE:          return 8;
        default:            return 4;
    endcase
endfunction

// little endian, lowest byte at the lowest address
function automatic void remember_store(input int ofs, input logic [63:0] data,
                                       input ls_type_e t);
    for (int i = 0; i < access_size(t); i++) begin
        ram_image[ofs + i] = data[8*i +: 8];
    end
endfunction

function automatic logic [63:0] expected_load(input int ofs, input ls_type_e t);
    logic [63:0] raw;
    raw = '0;
    for (int i = 0; i < access_size(t); i++) begin
        raw[8*i +: 8] = ram_image[ofs + i];
    end
    case (t)
        LS_BYTE: return {{56{raw[7]}}, raw[7:0]};
        LS_HALF: return {{48{raw[15]}}, raw[15:0]};
        LS_WORD: return {{32{raw[31]}}, raw[31:0]};
        // unsigned loads and doublewords pass through
        default: return raw;
    endcase
endfunction

// only the external source can be claimed
function automatic logic [31:0] expected_claim(input int ctx);
    if (pending_model[`IRQ_SRC_ID] && enable_model[ctx][`IRQ_SRC_ID]) begin
        return 32'(`IRQ_SRC_ID);
    end
    return 32'd0;
endfunction

`endif

/* tests/tb_soc_bus.sv */
`include "soc_bus_defs.svh"

`timescale 1ns/100ps

`default_nettype none

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int NUM_OPS        = 16 + 300 + 20 + 15 + 3;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 8 + 100;
    localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_4000_0000;

    logic        clock_slow;
    logic        KEY0;
    logic        irq;
    logic        meip;
    logic        seip;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    `include "tb_ref_model.svh"

    soc_bus_top soc_bus_top_inst (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .irq        (irq),
        .meip       (meip),
        .seip       (seip)
    );

    always #2 clock_slow = ~clock_slow;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] ram_addr(input int ofs);
        return `RAM_BASE + 64'(ofs);
    endfunction

    function automatic logic [63:0] plic_addr(input logic [23:0] ofs);
        return `PLIC_BASE + 64'(ofs);
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // called just after a rising edge, returns just after the done edge
    task automatic write_access(input logic [63:0] addr, input logic [63:0] data,
                                input ls_type_e t);
        bus_req.addr    = addr;
        bus_req.wdata   = data;
        bus_req.ls_type = t;
        bus_req.write   = 1'b1;
        @(posedge clock_slow);
        #0.5;
        bus_req.write = 1'b0;
        while (!bus_rsp.write_done) begin
            @(posedge clock_slow);
            #0.5;
        end
    endtask

    task automatic read_access(input logic [63:0] addr, input ls_type_e t,
                               output logic [63:0] data);
        bus_req.addr    = addr;
        bus_req.ls_type = t;
        bus_req.read    = 1'b1;
        @(posedge clock_slow);
        #0.5;
        bus_req.read = 1'b0;
        while (!bus_rsp.read_done) begin
            @(posedge clock_slow);
            #0.5;
        end
        data = bus_rsp.rdata;
    endtask

    task automatic check_outputs(input string what);
        check_equal(64'(meip), 64'(expected_claim(0) != 0), {what, ", meip"});
        check_equal(64'(seip), 64'(expected_claim(1) != 0), {what, ", seip"});
    endtask

    // set enables, raise irq, then claim twice on one context
    task automatic irq_round(input logic [31:0] en0, input logic [31:0] en1, input int ctx);
        logic [63:0] rd;
        logic [31:0] id;
        logic [23:0] claim_ofs;
        claim_ofs = `PLIC_CLAIM_OFS + 24'(ctx) * `PLIC_CTX_STRIDE;
        write_access(plic_addr(`PLIC_ENABLE_OFS), 64'(en0), LS_WORD);
        enable_model[0] = en0;
        write_access(plic_addr(`PLIC_ENABLE_OFS + `PLIC_CTX_ENABLE_STRIDE), 64'(en1), LS_WORD);
        enable_model[1] = en1;
        irq = 1'b1;
        pending_model[`IRQ_SRC_ID] = 1'b1;
        read_access(plic_addr(`PLIC_PENDING_OFS), LS_WORD, rd);
        check_equal(rd, 64'(pending_model), "pending after irq edge");
        check_outputs("after irq edge");
        repeat (2) begin
            id = expected_claim(ctx);
            read_access(plic_addr(claim_ofs), LS_WORD, rd);
            check_equal(rd, 64'(id), $sformatf("claim on context %0d", ctx));
            if (id != 0) begin
                pending_model[id[4:0]] = 1'b0;
            end
            check_outputs("after claim");
        end
        irq = 1'b0;
    endtask

    initial begin
        ls_type_e    t;
        int          ofs;
        logic [63:0] data;
        logic [63:0] rd;
        logic [23:0] reg_ofs;
        clock_slow = 1'b0;
        KEY0       = 1'b0;
        irq        = 1'b0;
        bus_req    = '0;
        lfsr_state = 32'hc8ce;
        errors     = 0;
        checks     = 0;
        pending_model = '0;
        repeat (3) @(posedge clock_slow);
        #0.5;
        KEY0 = 1'b1;

        check_equal(64'(bus_rsp.read_done), 64'd1, "read_done after reset");
        check_equal(64'(bus_rsp.write_done), 64'd1, "write_done after reset");
        check_equal(bus_rsp.rdata, 64'd0, "rdata after reset");
        check_equal(64'(meip), 64'd0, "meip after reset");
        check_equal(64'(seip), 64'd0, "seip after reset");

        // ram starts undefined, so fill the window first
        for (int w = 0; w < WINDOW_BYTES / 4; w++) begin
            data = random_bits(32);
            write_access(ram_addr(w * 4), data, LS_WORD);
            remember_store(w * 4, data, LS_WORD);
        end

        for (int n = 0; n < 300; n++) begin
            t   = ls_type_e'(3'(random_bits(3) % 7));
            ofs = int'(random_bits(4)) * 4;
            case (access_size(t))
                1: ofs = ofs + int'(random_bits(2));
                2: ofs = ofs + int'(random_bits(1)) * 2;
                8: ofs = ofs & ~7;
                default: ;
            endcase
            if (random_bits(1) != 0) begin
                data = random_bits(64);
                write_access(ram_addr(ofs), data, t);
                remember_store(ofs, data, t);
            end else begin
                read_access(ram_addr(ofs), t, rd);
                check_equal(rd, expected_load(ofs, t),
                            $sformatf("load %s at %0d", t.name(), ofs));
            end
        end

        // write every slot before reading any, so aliased slots show up
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            data = random_bits(32);
            write_access(plic_addr(24'(i * 4)), data, LS_WORD);
            prio_model[i] = data[`PRIO_W-1:0];
        end
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            read_access(plic_addr(24'(i * 4)), LS_WORD, rd);
            check_equal(rd, 64'(prio_model[i]), "priority read-back");
        end
        for (int c = 0; c < 2; c++) begin
            reg_ofs = `PLIC_ENABLE_OFS + 24'(c) * `PLIC_CTX_ENABLE_STRIDE;
            data = random_bits(32);
            write_access(plic_addr(reg_ofs), data, LS_WORD);
            enable_model[c] = data[31:0];
            reg_ofs = `PLIC_THRESH_OFS + 24'(c) * `PLIC_CTX_STRIDE;
            data = random_bits(32);
            write_access(plic_addr(reg_ofs), data, LS_WORD);
            thresh_model[c] = data[`PRIO_W-1:0];
        end
        for (int c = 0; c < 2; c++) begin
            reg_ofs = `PLIC_ENABLE_OFS + 24'(c) * `PLIC_CTX_ENABLE_STRIDE;
            read_access(plic_addr(reg_ofs), LS_WORD, rd);
            check_equal(rd, 64'(enable_model[c]), "enable read-back");
            reg_ofs = `PLIC_THRESH_OFS + 24'(c) * `PLIC_CTX_STRIDE;
            read_access(plic_addr(reg_ofs), LS_WORD, rd);
            check_equal(rd, 64'(thresh_model[c]), "threshold read-back");
        end

        irq_round(32'(1) << `IRQ_SRC_ID, 32'd0, 0);
        irq_round(32'd0, 32'(1) << `IRQ_SRC_ID, 1);
        // enables off, pending sets but no output rises
        irq_round(32'd0, 32'd0, 0);

        // leaves nonzero read data behind for the unmapped load to replace
        read_access(plic_addr(`PLIC_PENDING_OFS), LS_WORD, rd);
        check_equal(rd, 64'(pending_model), "pending before unmapped load");

        write_access(UNMAPPED_ADDR, random_bits(64), LS_DOUBLE);
        read_access(UNMAPPED_ADDR, LS_DOUBLE, rd);
        check_equal(rd, 64'd0, "unmapped load");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock_slow);
        $display("timeout: a bus access did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src/soc_bus_top.sv */
`timescale 1ns/100ps

`default_nettype none

module soc_bus_top (
    input  logic                  clock_slow,
    input  logic                  KEY0,
    input  soc_bus_pkg::bus_req_t bus_req,
    output soc_bus_pkg::bus_rsp_t bus_rsp,
    input  logic                  irq,
    output logic                  meip,
    output logic                  seip
);
    import soc_bus_pkg::*;

    slave_cmd_t ram_cmd;
    slave_rsp_t ram_rsp;
    slave_cmd_t plic_cmd;
    slave_rsp_t plic_rsp;

    bus_ctrl bus_ctrl_inst (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ram_cmd    (ram_cmd),
        .ram_rsp    (ram_rsp),
        .plic_cmd   (plic_cmd),
        .plic_rsp   (plic_rsp)
    );

    ram_bank ram_bank_inst (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .cmd        (ram_cmd),
        .rsp        (ram_rsp)
    );

    // external irq enters here and sets pending bit 1
    plic_regs plic_regs_inst (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .cmd        (plic_cmd),
        .rsp        (plic_rsp),
        .irq        (irq),
        .meip       (meip),
        .seip       (seip)
    );

endmodule

`default_nettype wire

/* src/plic_regs.sv */
`include "soc_bus_defs.svh"

`timescale 1ns/100ps

`default_nettype none

module plic_regs (
    input  logic                    clock_slow,
    input  logic                    KEY0,
    input  soc_bus_pkg::slave_cmd_t cmd,
    output soc_bus_pkg::slave_rsp_t rsp,
    input  logic                    irq,
    output logic                    meip,
    output logic                    seip
);
    import soc_bus_pkg::*;

    // context 0 is M, context 1 is S
    localparam int NCTX = 2;
    localparam int ID_W = $clog2(`PLIC_SOURCES);

    logic [`PRIO_W-1:0] prio [`PLIC_SOURCES];
    logic [31:0]        pending;
    logic [31:0]        enable [NCTX];
    logic [`PRIO_W-1:0] thresh [NCTX];
    logic [31:0]        claim [NCTX];

    logic               irq_q;
    logic               irq_rise;

    logic [ID_W-1:0]    prio_id;
    logic               prio_hit;
    logic               pend_hit;
    logic [NCTX-1:0]    en_hit;
    logic [NCTX-1:0]    th_hit;
    logic [NCTX-1:0]    cl_hit;
    logic [63:0]        rdata;

    assign irq_rise = irq & ~irq_q;

    assign prio_id  = cmd.ofs[ID_W+1:2];
    assign prio_hit = (cmd.ofs < `PLIC_SOURCES * 4);
    assign pend_hit = (cmd.ofs == `PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < NCTX; c++) begin
            en_hit[c] = (cmd.ofs == `PLIC_ENABLE_OFS + c * `PLIC_CTX_ENABLE_STRIDE);
            th_hit[c] = (cmd.ofs == `PLIC_THRESH_OFS + c * `PLIC_CTX_STRIDE);
            cl_hit[c] = (cmd.ofs == `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE);
            // only the external irq source can be claimed
            if (pending[`IRQ_SRC_ID] && enable[c][`IRQ_SRC_ID]) begin
                claim[c] = 32'(`IRQ_SRC_ID);
            end else begin
                claim[c] = 32'd0;
            end
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        rdata = '0;
        if (prio_hit) begin
            rdata = 64'(prio[prio_id]);
        end else if (pend_hit) begin
            rdata = 64'(pending);
        end
        for (int c = 0; c < NCTX; c++) begin
            if (en_hit[c]) begin
                rdata = 64'(enable[c]);
            end
            if (th_hit[c]) begin
                rdata = 64'(thresh[c]);
            end
            if (cl_hit[c]) begin
                rdata = 64'(claim[c]);
            end
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            irq_q   <= 1'b0;
            pending <= '0;
            for (int i = 0; i < `PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < NCTX; c++) begin
                enable[c] <= '0;
                thresh[c] <= '0;
            end
        end else begin
            irq_q <= irq;
            if (cmd.stb && cmd.we) begin
                if (prio_hit) begin
                    prio[prio_id] <= cmd.wdata[`PRIO_W-1:0];
                end
                for (int c = 0; c < NCTX; c++) begin
                    if (en_hit[c]) begin
                        enable[c] <= cmd.wdata[31:0];
                    end
                    if (th_hit[c]) begin
                        thresh[c] <= cmd.wdata[`PRIO_W-1:0];
                    end
                end
            end
            // claim read clears the id it returns
            if (cmd.stb && !cmd.we) begin
                for (int c = 0; c < NCTX; c++) begin
                    if (cl_hit[c] && claim[c] != 32'd0) begin
                        pending[claim[c][4:0]] <= 1'b0;
                    end
                end
            end
            // a new edge beats a claim in the same cycle
            if (irq_rise) begin
                pending[`IRQ_SRC_ID] <= 1'b1;
            end
        end
    end

    assign rsp  = '{ack: cmd.stb, rdata: rdata};
    assign meip = (claim[0] != 32'd0);
    assign seip = (claim[1] != 32'd0);

endmodule

`default_nettype wire

/* src/ram_bank.sv */
`include "soc_bus_defs.svh"

`timescale 1ns/100ps

`default_nettype none

module ram_bank (
    input  logic                    clock_slow,
    input  logic                    KEY0,
    input  soc_bus_pkg::slave_cmd_t cmd,
    output soc_bus_pkg::slave_rsp_t rsp
);
    import soc_bus_pkg::*;

    localparam int AW = $clog2(`RAM_WORDS);

    ram_word_u       mem [`RAM_WORDS];

    logic [AW-1:0]   widx;
    logic [1:0]      lane;

    // second word of a doubleword
    logic [AW-1:0]   hi_idx;
    logic [31:0]     hi_wdata;
    logic            hi_we;

    logic            step;
    logic            ack_q;
    logic [63:0]     rdata_q;

    // pick the lane and extend it by load type
    function automatic logic [63:0] load_ext(ram_word_u w, logic [1:0] ln, ls_type_e t);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.b[ln];
        h = w.h[ln[1]];
        case (t)
            LS_BYTE:   return {{56{b[7]}}, b};
            LS_BYTE_U: return {56'd0, b};
            LS_HALF:   return {{48{h[15]}}, h};
            LS_HALF_U: return {48'd0, h};
            LS_WORD:   return {{32{w[31]}}, w};
            // unsigned word and low half of a doubleword
            default:   return {32'd0, w};
        endcase
    endfunction

    assign widx = cmd.ofs[AW+1:2];
    assign lane = cmd.ofs[1:0];

    always_ff @(posedge clock_slow) begin
        if (cmd.stb) begin
            hi_idx   <= widx + 1'b1;
            hi_wdata <= cmd.wdata[63:32];
            hi_we    <= cmd.we;
            rdata_q  <= load_ext(mem[widx], lane, cmd.ls_type);
            if (cmd.we) begin
                case (cmd.ls_type)
                    LS_BYTE, LS_BYTE_U: mem[widx].b[lane] <= cmd.wdata[7:0];
                    LS_HALF, LS_HALF_U: mem[widx].h[lane[1]] <= cmd.wdata[15:0];
                    default:            mem[widx] <= cmd.wdata[31:0];
                endcase
            end
        end else if (step) begin
            rdata_q[63:32] <= mem[hi_idx];
            if (hi_we) begin
                mem[hi_idx] <= hi_wdata;
            end
        end
    end

    // word and smaller ack next cycle, doubleword one later
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            step  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            step  <= 1'b0;
            ack_q <= 1'b0;
            if (cmd.stb) begin
                if (cmd.ls_type == LS_DOUBLE) begin
                    step <= 1'b1;
                end else begin
                    ack_q <= 1'b1;
                end
            end else if (step) begin
                ack_q <= 1'b1;
            end
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* src/bus_ctrl.sv */
`include "soc_bus_defs.svh"

`timescale 1ns/100ps

`default_nettype none

module bus_ctrl (
    input  logic                    clock_slow,
    input  logic                    KEY0,
    input  soc_bus_pkg::bus_req_t   bus_req,
    output soc_bus_pkg::bus_rsp_t   bus_rsp,
    output soc_bus_pkg::slave_cmd_t ram_cmd,
    input  soc_bus_pkg::slave_rsp_t ram_rsp,
    output soc_bus_pkg::slave_cmd_t plic_cmd,
    input  soc_bus_pkg::slave_rsp_t plic_rsp
);
    import soc_bus_pkg::*;

    // decode of the incoming address
    slave_sel_e        sel;
    logic [`OFS_W-1:0] ofs;
    logic              req;

    // captured request payload
    logic              we_q;
    logic [`OFS_W-1:0] ofs_q;
    logic [63:0]       wdata_q;
    ls_type_e          ls_q;

    // control state
    slave_sel_e        sel_q;
    logic              ram_stb;
    logic              plic_stb;
    logic              none_pend;
    logic              read_done;
    logic              write_done;
    logic [63:0]       rdata_q;

    // end of access from whichever target was selected
    logic              ack;
    logic [63:0]       ack_data;

    assign req = bus_req.read | bus_req.write;

    always_comb begin
        sel = SEL_NONE;
        ofs = '0;
        if (bus_req.addr >= `RAM_BASE && bus_req.addr < `RAM_BASE + `RAM_SPAN) begin
            sel = SEL_RAM;
            ofs = `OFS_W'(bus_req.addr - `RAM_BASE);
        end else if (bus_req.addr >= `PLIC_BASE &&
                     bus_req.addr < `PLIC_BASE + `PLIC_SPAN) begin
            sel = SEL_PLIC;
            ofs = `OFS_W'(bus_req.addr - `PLIC_BASE);
        end
    end

    always_ff @(posedge clock_slow) begin
        if (req) begin
            we_q    <= bus_req.write;
            ofs_q   <= ofs;
            wdata_q <= bus_req.wdata;
            ls_q    <= bus_req.ls_type;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_RAM: begin
                ack      = ram_rsp.ack;
                ack_data = ram_rsp.rdata;
            end
            SEL_PLIC: begin
                ack      = plic_rsp.ack;
                ack_data = plic_rsp.rdata;
            end
            default: begin
                // unmapped, finish one cycle later with zero data
                ack      = none_pend;
                ack_data = '0;
            end
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            sel_q      <= SEL_NONE;
            ram_stb    <= 1'b0;
            plic_stb   <= 1'b0;
            none_pend  <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            rdata_q    <= '0;
        end else begin
            ram_stb   <= 1'b0;
            plic_stb  <= 1'b0;
            none_pend <= 1'b0;
            if (req) begin
                if (bus_req.read) begin
                    read_done <= 1'b0;
                end
                if (bus_req.write) begin
                    write_done <= 1'b0;
                end
                sel_q     <= sel;
                ram_stb   <= (sel == SEL_RAM);
                plic_stb  <= (sel == SEL_PLIC);
                none_pend <= (sel == SEL_NONE);
            end
            if (ack) begin
                if (we_q) begin
                    write_done <= 1'b1;
                end else begin
                    read_done <= 1'b1;
                    rdata_q   <= ack_data;
                end
            end
        end
    end

    // same payload to both slaves, only the strobe differs
    assign ram_cmd  = '{stb: ram_stb, we: we_q, ofs: ofs_q, wdata: wdata_q, ls_type: ls_q};
    assign plic_cmd = '{stb: plic_stb, we: we_q, ofs: ofs_q, wdata: wdata_q, ls_type: ls_q};

    assign bus_rsp = '{rdata: rdata_q, read_done: read_done, write_done: write_done};

endmodule

`default_nettype wire

/* src/soc_bus_pkg.sv */
`include "soc_bus_defs.svh"

`default_nettype none

package soc_bus_pkg;

    // load/store type as issued by the cpu
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,
        LS_HALF   = 3'd1,
        LS_WORD   = 3'd2,
        LS_DOUBLE = 3'd3,
        LS_BYTE_U = 3'd4,
        LS_HALF_U = 3'd5,
        LS_WORD_U = 3'd6
    } ls_type_e;

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        ls_type_e    ls_type;
        logic        read;
        logic        write;
    } bus_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        read_done;
        logic        write_done;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_RAM  = 2'd1,
        SEL_PLIC = 2'd2
    } slave_sel_e;

    // controller to slave, stb is a single cycle
    typedef struct packed {
        logic              stb;
        logic              we;
        logic [`OFS_W-1:0] ofs;
        logic [63:0]       wdata;
        ls_type_e          ls_type;
    } slave_cmd_t;

    typedef struct packed {
        logic        ack;
        logic [63:0] rdata;
    } slave_rsp_t;

    // one ram word, by byte lane or by half
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } ram_word_u;

endpackage

`default_nettype wire

/* src/soc_bus_defs.svh */
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

`default_nettype none

// address map
`define RAM_BASE            (64'h0000_0000_8000_0000)
`define RAM_WORDS           (512)
`define RAM_SPAN            (`RAM_WORDS * 4)
`define PLIC_BASE           (64'h0000_0000_0C00_0000)
`define PLIC_SPAN           (64'h0000_0000_0100_0000)

// slave register offset width
`define OFS_W               (24)

// interrupt controller register offsets
`define PLIC_PENDING_OFS    (24'h00_1000)
`define PLIC_ENABLE_OFS     (24'h00_2000)
`define PLIC_THRESH_OFS     (24'h20_0000)
`define PLIC_CLAIM_OFS      (24'h20_0004)

// per-context strides
`define PLIC_CTX_ENABLE_STRIDE (24'h00_0080)
`define PLIC_CTX_STRIDE     (24'h00_1000)

`define PLIC_SOURCES        (6)
`define PRIO_W              (3)
`define IRQ_SRC_ID          (1)

`default_nettype wire

`endif
